//--- design/rtc_map_pkg.sv
package rtc_map_pkg;

   localparam int NUM_FIELDS = 12;

   typedef logic [7:0] reg_byte_t;
   typedef logic [7:0] rtc_addr_t;

   // bank positions, format byte first
   typedef enum logic [3:0] {
      fmt,
      sec,
      min,
      hour,
      date,
      month,
      year,
      wday,
      week,
      sw_sec,
      sw_min,
      sw_hour
   } field_t;

   // live values from the RTC, index 0 = sec
   typedef reg_byte_t [7:0] clock_bank_t;

   // stopwatch values, index 0 = sw_sec
   typedef reg_byte_t [2:0] timer_bank_t;

   typedef reg_byte_t [NUM_FIELDS-1:0] field_bank_t;

   // register map
   localparam rtc_addr_t ADDR_CTRL       = 8'h00; // control and 12/24h format
   localparam rtc_addr_t ADDR_CLOCK_BASE = 8'h21; // sec, up to week at 0x28
   localparam rtc_addr_t ADDR_TIMER_BASE = 8'h41; // sw_sec, up to sw_hour at 0x43

   // bytes for the control register
   localparam reg_byte_t FMT_24H       = 8'h10;
   localparam reg_byte_t FMT_12H       = 8'h00;
   localparam reg_byte_t CMD_TIMER_RUN = 8'h08;

endpackage

//--- design/edit_ctrl_pkg.sv
package edit_ctrl_pkg;

   typedef enum logic [1:0] {
      mode_idle,
      mode_clock,  // clock and calendar fields
      mode_timer,  // stopwatch fields
      mode_run     // stopwatch running
   } edit_mode_t;

   typedef enum logic [2:0] {
      key_none,
      key_up,
      key_down,
      key_left,
      key_right
   } key_cmd_t;

endpackage

//--- design/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  logic                     clock_edit,
   input  logic                     timer_edit,
   input  logic                     timer_running,
   input  logic                     rtc_sync,
   input  logic                     key_up,
   input  logic                     key_down,
   input  logic                     key_left,
   input  logic                     key_right,
   output edit_ctrl_pkg::edit_mode_t mode,
   output edit_ctrl_pkg::key_cmd_t   cmd,
   output logic                     sync
);

   logic [2:0]                levels;
   logic [3:0]                keys;
   edit_ctrl_pkg::edit_mode_t mode_d;
   edit_ctrl_pkg::key_cmd_t   cmd_d;

   assign levels = {clock_edit, timer_edit, timer_running};
   assign keys   = {key_up, key_down, key_left, key_right};

   always_comb begin
      mode_d = edit_ctrl_pkg::mode_idle;
      if (!start) begin
         case (levels)
            3'b100:  mode_d = edit_ctrl_pkg::mode_clock;
            3'b010:  mode_d = edit_ctrl_pkg::mode_timer;
            3'b001:  mode_d = edit_ctrl_pkg::mode_run;
            default: mode_d = edit_ctrl_pkg::mode_idle; // none or conflicting
         endcase
      end

      case (keys)
         4'b1000: cmd_d = edit_ctrl_pkg::key_up;
         4'b0100: cmd_d = edit_ctrl_pkg::key_down;
         4'b0010: cmd_d = edit_ctrl_pkg::key_left;
         4'b0001: cmd_d = edit_ctrl_pkg::key_right;
         default: cmd_d = edit_ctrl_pkg::key_none; // chords count as nothing
      endcase

      // keys only mean something while editing
      if (mode_d != edit_ctrl_pkg::mode_clock && mode_d != edit_ctrl_pkg::mode_timer) begin
         cmd_d = edit_ctrl_pkg::key_none;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mode <= edit_ctrl_pkg::mode_idle;
         cmd  <= edit_ctrl_pkg::key_none;
         sync <= 1'b0;
      end else begin
         mode <= mode_d;
         cmd  <= cmd_d;
         sync <= rtc_sync;
      end
   end

endmodule

//--- design/field_navigator.sv
`timescale 1ns/1ps

module field_navigator (
   input  logic                      clk,
   input  logic                      reset,
   input  edit_ctrl_pkg::edit_mode_t mode,
   input  edit_ctrl_pkg::key_cmd_t   cmd,
   output rtc_map_pkg::field_t       field,
   output edit_ctrl_pkg::edit_mode_t mode_q
);

   rtc_map_pkg::field_t field_d;

   // one step around the ring first..last
   function automatic rtc_map_pkg::field_t ring_step(
      input rtc_map_pkg::field_t     cur,
      input rtc_map_pkg::field_t     first,
      input rtc_map_pkg::field_t     last,
      input edit_ctrl_pkg::key_cmd_t key
   );
      rtc_map_pkg::field_t nxt;
      nxt = cur;
      if (key == edit_ctrl_pkg::key_right) begin
         if (cur == last)
            nxt = first; // wrap forward
         else
            nxt = rtc_map_pkg::field_t'(cur + 4'd1);
      end else if (key == edit_ctrl_pkg::key_left) begin
         if (cur == first)
            nxt = last; // wrap back
         else
            nxt = rtc_map_pkg::field_t'(cur - 4'd1);
      end
      return nxt;
   endfunction

   always_comb begin
      case (mode)
         edit_ctrl_pkg::mode_clock: begin
            if (field >= rtc_map_pkg::sw_sec)
               field_d = rtc_map_pkg::fmt; // coming from the stopwatch
            else
               field_d = ring_step(field, rtc_map_pkg::fmt, rtc_map_pkg::week, cmd);
         end
         edit_ctrl_pkg::mode_timer: begin
            if (field < rtc_map_pkg::sw_sec)
               field_d = rtc_map_pkg::sw_sec; // entry jump beats a key
            else
               field_d = ring_step(field, rtc_map_pkg::sw_sec, rtc_map_pkg::sw_hour, cmd);
         end
         default: field_d = rtc_map_pkg::fmt; // idle and run park on fmt
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         field  <= rtc_map_pkg::fmt;
         mode_q <= edit_ctrl_pkg::mode_idle;
      end else begin
         field  <= field_d;
         mode_q <= mode; // same stage as field
      end
   end

endmodule

//--- design/field_bank.sv
`timescale 1ns/1ps

module field_bank (
   input  logic                     clk,
   input  logic                     reset,
   input  rtc_map_pkg::field_t      field,
   input  edit_ctrl_pkg::key_cmd_t  cmd,
   input  logic                     sync,
   input  rtc_map_pkg::clock_bank_t clock_values,
   input  rtc_map_pkg::timer_bank_t timer_values,
   output rtc_map_pkg::field_bank_t bank
);

   rtc_map_pkg::reg_byte_t cur;
   rtc_map_pkg::reg_byte_t up_val;
   rtc_map_pkg::reg_byte_t down_val;
   logic                   is_fmt;

   assign cur    = bank[field];
   assign is_fmt = (field == rtc_map_pkg::fmt);

   // fmt takes fixed bytes, the rest count mod 256
   assign up_val   = is_fmt ? rtc_map_pkg::FMT_24H : cur + 8'd1;
   assign down_val = is_fmt ? rtc_map_pkg::FMT_12H : cur - 8'd1;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bank <= '0;
      end else if (sync) begin
         // reload from the live RTC, fmt untouched
         bank[rtc_map_pkg::week:rtc_map_pkg::sec]       <= clock_values;
         bank[rtc_map_pkg::sw_hour:rtc_map_pkg::sw_sec] <= timer_values;
      end else begin
         case (cmd)
            edit_ctrl_pkg::key_up:   bank[field] <= up_val;
            edit_ctrl_pkg::key_down: bank[field] <= down_val;
            default: ;
         endcase
      end
   end

endmodule

//--- design/bus_driver.sv
`timescale 1ns/1ps

module bus_driver (
   input  logic                      clk,
   input  logic                      reset,
   input  edit_ctrl_pkg::edit_mode_t mode,
   input  rtc_map_pkg::field_t       field,
   input  rtc_map_pkg::field_bank_t  bank,
   output rtc_map_pkg::rtc_addr_t    address,
   output rtc_map_pkg::reg_byte_t    data,
   output logic                      write_active
);

   rtc_map_pkg::rtc_addr_t address_d;
   rtc_map_pkg::reg_byte_t data_d;
   logic                   active_d;

   // register address of a bank position
   function automatic rtc_map_pkg::rtc_addr_t field_addr(input rtc_map_pkg::field_t f);
      rtc_map_pkg::rtc_addr_t pos;
      rtc_map_pkg::rtc_addr_t addr;
      pos = {4'h0, f};
      if (f == rtc_map_pkg::fmt)
         addr = rtc_map_pkg::ADDR_CTRL;
      else if (f >= rtc_map_pkg::sw_sec)
         addr = rtc_map_pkg::ADDR_TIMER_BASE + pos - {4'h0, rtc_map_pkg::sw_sec};
      else
         addr = rtc_map_pkg::ADDR_CLOCK_BASE + pos - {4'h0, rtc_map_pkg::sec};
      return addr;
   endfunction

   always_comb begin
      case (mode)
         edit_ctrl_pkg::mode_clock,
         edit_ctrl_pkg::mode_timer: begin
            address_d = field_addr(field);
            data_d    = bank[field];
            active_d  = 1'b1;
         end
         edit_ctrl_pkg::mode_run: begin
            address_d = rtc_map_pkg::ADDR_CTRL;
            data_d    = rtc_map_pkg::CMD_TIMER_RUN; // start the stopwatch
            active_d  = 1'b1;
         end
         default: begin
            address_d = rtc_map_pkg::ADDR_CTRL;
            data_d    = '0;
            active_d  = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address      <= '0;
         data         <= '0;
         write_active <= 1'b0;
      end else begin
         address      <= address_d;
         data         <= data_d;
         write_active <= active_d;
      end
   end

endmodule

//--- design/rtc_editor.sv
`timescale 1ns/1ps

module rtc_editor (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  logic                     clock_edit,
   input  logic                     timer_edit,
   input  logic                     timer_running,
   input  logic                     rtc_sync,
   input  logic                     key_up,
   input  logic                     key_down,
   input  logic                     key_left,
   input  logic                     key_right,
   input  rtc_map_pkg::clock_bank_t clock_values,
   input  rtc_map_pkg::timer_bank_t timer_values,
   output rtc_map_pkg::rtc_addr_t   address,
   output rtc_map_pkg::reg_byte_t   data,
   output logic                     write_active
);

   edit_ctrl_pkg::edit_mode_t mode;
   edit_ctrl_pkg::edit_mode_t mode_q;   // aligned with field
   edit_ctrl_pkg::key_cmd_t   cmd;
   logic                      sync;
   rtc_map_pkg::field_t       field;
   rtc_map_pkg::field_bank_t  bank;

   key_decoder i_key_decoder (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .clock_edit    (clock_edit),
      .timer_edit    (timer_edit),
      .timer_running (timer_running),
      .rtc_sync      (rtc_sync),
      .key_up        (key_up),
      .key_down      (key_down),
      .key_left      (key_left),
      .key_right     (key_right),
      .mode          (mode),
      .cmd           (cmd),
      .sync          (sync)
   );

   field_navigator i_field_navigator (
      .clk    (clk),
      .reset  (reset),
      .mode   (mode),
      .cmd    (cmd),
      .field  (field),
      .mode_q (mode_q)
   );

   // acts on the field held before the edge
   field_bank i_field_bank (
      .clk          (clk),
      .reset        (reset),
      .field        (field),
      .cmd          (cmd),
      .sync         (sync),
      .clock_values (clock_values),
      .timer_values (timer_values),
      .bank         (bank)
   );

   bus_driver i_bus_driver (
      .clk          (clk),
      .reset        (reset),
      .mode         (mode_q),
      .field        (field),
      .bank         (bank),
      .address      (address),
      .data         (data),
      .write_active (write_active)
   );

endmodule

//--- verification/rtc_editor_model.svh
`ifndef RTC_EDITOR_MODEL_SVH
`define RTC_EDITOR_MODEL_SVH

rtc_map_pkg::field_t       m_field;
rtc_map_pkg::field_bank_t  m_bank;
edit_ctrl_pkg::edit_mode_t m_mode;

// exactly one level and no start selects a mode
function automatic edit_ctrl_pkg::edit_mode_t decode_mode(input logic [3:0] lv);
   edit_ctrl_pkg::edit_mode_t md;
   md = edit_ctrl_pkg::mode_idle;
   if (lv == 4'b0100) md = edit_ctrl_pkg::mode_clock;
   if (lv == 4'b0010) md = edit_ctrl_pkg::mode_timer;
   if (lv == 4'b0001) md = edit_ctrl_pkg::mode_run;
   return md;
endfunction

function automatic edit_ctrl_pkg::key_cmd_t decode_key(input logic [3:0] k,
                                                       input edit_ctrl_pkg::edit_mode_t md);
   edit_ctrl_pkg::key_cmd_t kc;
   kc = edit_ctrl_pkg::key_none;
   if (md == edit_ctrl_pkg::mode_clock || md == edit_ctrl_pkg::mode_timer) begin
      if (k == 4'b1000) kc = edit_ctrl_pkg::key_up;
      if (k == 4'b0100) kc = edit_ctrl_pkg::key_down;
      if (k == 4'b0010) kc = edit_ctrl_pkg::key_left;
      if (k == 4'b0001) kc = edit_ctrl_pkg::key_right;
   end
   return kc;
endfunction

// one sampled input cycle applied to the tracked state
function void model_step(input logic [3:0] lv, input logic sy, input logic [3:0] k,
                         input rtc_map_pkg::clock_bank_t cv,
                         input rtc_map_pkg::timer_bank_t tv);
   edit_ctrl_pkg::edit_mode_t md;
   edit_ctrl_pkg::key_cmd_t   kc;
   int                        f;
   md = decode_mode(lv);
   kc = decode_key(k, md);
   f  = int'(m_field);
   if (sy) begin
      for (int i = 0; i < 8; i++) m_bank[i + 1] = cv[i];
      for (int i = 0; i < 3; i++) m_bank[i + 9] = tv[i];
   end else if (kc == edit_ctrl_pkg::key_up) begin
      m_bank[f] = (f == 0) ? 8'h10 : m_bank[f] + 8'd1;
   end else if (kc == edit_ctrl_pkg::key_down) begin
      m_bank[f] = (f == 0) ? 8'h00 : m_bank[f] - 8'd1;
   end
   if (md == edit_ctrl_pkg::mode_clock) begin
      if (f >= 9) f = 0;
      else if (kc == edit_ctrl_pkg::key_right) f = (f == 8) ? 0 : f + 1;
      else if (kc == edit_ctrl_pkg::key_left) f = (f == 0) ? 8 : f - 1;
   end else if (md == edit_ctrl_pkg::mode_timer) begin
      if (f < 9) f = 9;
      else if (kc == edit_ctrl_pkg::key_right) f = (f == 11) ? 9 : f + 1;
      else if (kc == edit_ctrl_pkg::key_left) f = (f == 9) ? 11 : f - 1;
   end else begin
      f = 0;
   end
   m_field = rtc_map_pkg::field_t'(f[3:0]);
   m_mode  = md;
endfunction

// {write_active, address, data} expected two cycles later
function automatic logic [16:0] expected_bus();
   int        f;
   logic [7:0] a;
   f = int'(m_field);
   a = (f == 0) ? 8'h00 : (f >= 9) ? 8'h41 + 8'(f - 9) : 8'h21 + 8'(f - 1);
   case (m_mode)
      edit_ctrl_pkg::mode_clock, edit_ctrl_pkg::mode_timer: return {1'b1, a, m_bank[f]};
      edit_ctrl_pkg::mode_run: return {1'b1, 8'h00, 8'h08};
      default: return {1'b0, 8'h00, 8'h00};
   endcase
endfunction

task automatic check_address(input string name, input rtc_map_pkg::rtc_addr_t exp,
                             input rtc_map_pkg::rtc_addr_t act);
   if (exp !== act) begin
      $display("** Error %s address: expected 0x%02h, actual 0x%02h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "address mismatch");
   end
endtask

task automatic check_data(input string name, input rtc_map_pkg::reg_byte_t exp,
                          input rtc_map_pkg::reg_byte_t act);
   if (exp !== act) begin
      $display("** Error %s data: expected 0x%02h, actual 0x%02h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "data mismatch");
   end
endtask

task automatic check_active(input string name, input logic exp, input logic act);
   if (exp !== act) begin
      $display("** Error %s write_active: expected %b, actual %b", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "write_active mismatch");
   end
endtask

`endif

//--- verification/rtc_editor_tb.sv
`timescale 1ns/1ps

module rtc_editor_tb;

   localparam int TEST_CYCLES = 450;
   localparam logic [3:0] LV_IDLE  = 4'b0000; // {start, clock, timer, running}
   localparam logic [3:0] LV_CLOCK = 4'b0100;
   localparam logic [3:0] LV_TIMER = 4'b0010;
   localparam logic [3:0] LV_RUN   = 4'b0001;

   logic clk;
   logic reset;
   logic start;
   logic clock_edit;
   logic timer_edit;
   logic timer_running;
   logic rtc_sync;
   logic key_up;
   logic key_down;
   logic key_left;
   logic key_right;
   rtc_map_pkg::clock_bank_t clock_values;
   rtc_map_pkg::timer_bank_t timer_values;
   rtc_map_pkg::rtc_addr_t   address;
   rtc_map_pkg::reg_byte_t   data;
   logic                     write_active;

   integer      seed;
   string       test_name;
   logic [16:0] exp_q[$];

   `include "rtc_editor_model.svh"

   rtc_editor i_rtc_editor (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .clock_edit    (clock_edit),
      .timer_edit    (timer_edit),
      .timer_running (timer_running),
      .rtc_sync      (rtc_sync),
      .key_up        (key_up),
      .key_down      (key_down),
      .key_left      (key_left),
      .key_right     (key_right),
      .clock_values  (clock_values),
      .timer_values  (timer_values),
      .address       (address),
      .data          (data),
      .write_active  (write_active)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // model sees the same inputs the DUT samples
   always @(posedge clk) begin
      if (!reset) begin
         model_step({start, clock_edit, timer_edit, timer_running}, rtc_sync,
                    {key_up, key_down, key_left, key_right}, clock_values, timer_values);
         exp_q.push_back(expected_bus());
      end
   end

   // outputs settled since the last rising edge
   always @(negedge clk) begin
      logic [16:0] e;
      if (exp_q.size() == 3) begin
         e = exp_q.pop_front();
         check_address(test_name, e[15:8], address);
         check_data(test_name, e[7:0], data);
         check_active(test_name, e[16], write_active);
      end
   end

   initial begin
      #((TEST_CYCLES + 100) * 40);
      $display("simulation timed out before the tests finished");
      $display("STATUS: FAIL");
      $fatal(1, "watchdog");
   end

   task automatic apply(input logic [3:0] lv, input logic sy, input logic [3:0] k);
      @(posedge clk);
      {start, clock_edit, timer_edit, timer_running} <= lv;
      rtc_sync <= sy;
      {key_up, key_down, key_left, key_right} <= k;
   endtask

   task automatic pulse(input logic [3:0] lv, input logic [3:0] k);
      apply(lv, 1'b0, k);
      apply(lv, 1'b0, 4'b0000);
   endtask

   // random key pulses with chords mixed in
   task automatic random_keys(input logic [3:0] lv, input int n, input logic nav_only);
      int         r;
      logic [3:0] k;
      for (int i = 0; i < n; i++) begin
         r = $random(seed);
         case (r[2:0])
            3'd0: k = nav_only ? 4'b0010 : 4'b1000;
            3'd1: k = nav_only ? 4'b0001 : 4'b0100;
            3'd2: k = 4'b0010;
            3'd3: k = 4'b0001;
            3'd4: k = 4'b0011;
            3'd5: k = 4'b1100;
            default: k = 4'b0000;
         endcase
         pulse(lv, k);
      end
   endtask

   task automatic load_rtc(input logic [3:0] lv);
      int r;
      @(posedge clk);
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         clock_values[i] <= r[7:0];
      end
      for (int i = 0; i < 3; i++) begin
         r = $random(seed);
         timer_values[i] <= r[7:0];
      end
      apply(lv, 1'b1, 4'b0100); // key in the reload cycle is dropped
      apply(lv, 1'b0, 4'b0000);
      apply(lv, 1'b0, 4'b0000);
   endtask

   initial begin
      seed = 49161;
      test_name = "reset";
      reset = 1'b1;
      {start, clock_edit, timer_edit, timer_running, rtc_sync} = '0;
      {key_up, key_down, key_left, key_right} = '0;
      clock_values = '0;
      timer_values = '0;
      m_field = rtc_map_pkg::fmt;
      m_bank = '0;
      m_mode = edit_ctrl_pkg::mode_idle;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      repeat (6) apply(LV_IDLE, 1'b0, 4'b0000);

      test_name = "clock_nav";
      random_keys(LV_CLOCK, 40, 1'b1);

      test_name = "fmt_edit";
      apply(LV_IDLE, 1'b0, 4'b0000);
      pulse(LV_CLOCK, 4'b1000);
      pulse(LV_CLOCK, 4'b0100);
      pulse(LV_CLOCK, 4'b1000);

      test_name = "wrap";
      pulse(LV_CLOCK, 4'b0001); // sec still 0x00
      pulse(LV_CLOCK, 4'b0100); // down to 0xff
      pulse(LV_CLOCK, 4'b1000); // up to 0x00

      test_name = "clock_edit";
      random_keys(LV_CLOCK, 60, 1'b0);

      test_name = "timer_edit";
      random_keys(LV_TIMER, 40, 1'b0);

      test_name = "reload";
      load_rtc(LV_CLOCK);
      random_keys(LV_CLOCK, 20, 1'b1);
      load_rtc(LV_TIMER);
      random_keys(LV_TIMER, 10, 1'b1);

      test_name = "mode_change";
      repeat (3) apply(LV_CLOCK, 1'b0, 4'b0000);
      apply(LV_CLOCK, 1'b0, 4'b0100); // fmt to 12h
      repeat (3) apply(LV_TIMER, 1'b0, 4'b0000);
      repeat (3) apply(LV_RUN, 1'b0, 4'b1000);
      repeat (3) apply(4'b1100, 1'b0, 4'b1000);
      repeat (3) apply(4'b0110, 1'b0, 4'b1000);
      repeat (3) apply(4'b0111, 1'b0, 4'b0000);
      repeat (2) apply(LV_TIMER, 1'b0, 4'b0000); // sw_sec read back
      repeat (2) apply(LV_CLOCK, 1'b0, 4'b0000); // fmt read back

      test_name = "drain";
      repeat (4) apply(LV_IDLE, 1'b0, 4'b0000);
      @(negedge clk);
      @(posedge clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- build.f
+incdir+verification
design/rtc_map_pkg.sv
design/edit_ctrl_pkg.sv
design/key_decoder.sv
design/field_navigator.sv
design/field_bank.sv
design/bus_driver.sv
design/rtc_editor.sv
verification/rtc_editor_tb.sv

//--- Makefile
BUILD_DIR := obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing -f build.f --top-module rtc_editor_tb -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/Vrtc_editor_tb | tee /dev/stderr | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing -f build.f --top-module rtc_editor_tb

clean:
	rm -rf $(BUILD_DIR)
